// ==== cpci_dma.f ====
+incdir+tests
source/dma_pkg.sv
source/dma_host_fsm.sv
source/dma_queue_port.sv
source/dma_rx_mux.sv
source/dma_regs.sv
source/cpci_dma.sv
tests/tb_cpci_dma.sv

// ==== tests/tb_cpci_dma_tasks.svh ====
// testbench helpers for the dma engine
//   value check and failure stop
//   host word traffic under host credits
//   rx packet scripting, register access, xorshift
`ifndef TB_CPCI_DMA_TASKS_SVH
`define TB_CPCI_DMA_TASKS_SVH

task automatic stop_with_failure();
   $display("Done: errors found");
   $fatal(1, "simulation stopped at first failure");
endtask

task automatic check(input string test_name, input logic [63:0] expected,
                     input logic [63:0] actual);
   if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
      stop_with_failure();
   end
endtask

task automatic report_timeout(input string what);
   $display("timeout: waited %0d cycles for %s", WAIT_LIMIT, what);
   stop_with_failure();
endtask

function automatic logic [31:0] next_rand();
   rng_state = rng_state ^ (rng_state << 13);
   rng_state = rng_state ^ (rng_state >> 17);
   rng_state = rng_state ^ (rng_state << 5);
   return rng_state;
endfunction

//////////////////////////////////////////////////
// host word channel
task automatic send_word(input logic is_req, input dma_word_u word);
   int waited;
   waited = 0;
   @(posedge cpci_clk);
   // only send while holding a credit
   while (HOST_CREDITS + credits_back - words_sent <= 0) begin
      dma_vld_c2n <= 1'b0;
      waited++;
      if (waited > WAIT_LIMIT)
         report_timeout("a host credit");
      @(posedge cpci_clk);
   end
   dma_vld_c2n    <= 1'b1;
   dma_is_req_c2n <= is_req;
   dma_word_c2n   <= word;
   words_sent++;
endtask

task automatic host_idle();
   @(posedge cpci_clk);
   dma_vld_c2n <= 1'b0;
endtask

task automatic tx_request(input int qid);
   dma_word_u w;
   w = '0;
   w.req_w.arg = qid;
   send_word(1'b1, w);
endtask

// random data, four bytes except a random count on the eop word
task automatic tx_data(input int qid, input int count, input logic with_eop);
   dma_word_u   w;
   logic [31:0] rnd;
   for (int k = 0; k < count; k++) begin
      w = '0;
      w.data_w.data = next_rand();
      if (with_eop && (k == count - 1)) begin
         rnd = next_rand();
         w.data_w.eop      = 1'b1;
         w.data_w.byte_cnt = rnd[1:0];
      end
      send_word(1'b0, w);
      exp_wr.push_back({QID_WIDTH'(qid), w});
   end
endtask

task automatic tx_packet(input int qid, input int len);
   tx_request(qid);
   tx_data(qid, len, 1'b1);
   host_idle();
endtask

task automatic expect_core_writes(input string test_name);
   int waited;
   waited = 0;
   while (wr_log.size() < exp_wr.size()) begin
      @(negedge cpci_clk);
      waited++;
      if (waited > WAIT_LIMIT)
         report_timeout("core queue writes");
   end
   // a few more cycles to catch extra writes
   repeat (8) @(negedge cpci_clk);
   check(test_name, exp_wr.size(), wr_log.size());
   while (exp_wr.size() > 0)
      check(test_name, exp_wr.pop_front(), wr_log.pop_front());
endtask

task automatic wait_credits_home();
   int waited;
   waited = 0;
   while (credits_back < words_sent) begin
      @(negedge cpci_clk);
      waited++;
      if (waited > WAIT_LIMIT)
         report_timeout("host credits to return");
   end
   repeat (4) @(negedge cpci_clk);
endtask

//////////////////////////////////////////////////
// rx packet, one host credit at a time
task automatic rx_packet(input string test_name, input int qid, input int len);
   dma_word_u   w;
   dma_word_u   exp_rx [$];
   logic [31:0] rnd;
   int          granted;
   int          waited;
   rx_log.delete();
   @(negedge cpci_clk);
   rx_src_qid = qid;
   for (int k = 0; k < len; k++) begin
      w = '0;
      w.data_w.data = next_rand();
      if (k == len - 1) begin
         rnd = next_rand();
         w.data_w.eop      = 1'b1;
         w.data_w.byte_cnt = rnd[1:0];
      end
      rx_src.push_back(w);
      exp_rx.push_back(w);
   end
   w = '0;
   w.req_w.dir_rx = 1'b1;
   w.req_w.arg    = qid;
   send_word(1'b1, w);
   host_idle();
   granted = 0;
   while (granted < len) begin
      @(posedge cpci_clk);
      dma_credit_c2n <= 1'b1;
      @(posedge cpci_clk);
      dma_credit_c2n <= 1'b0;
      granted++;
      waited = 0;
      while (rx_log.size() < granted) begin
         @(negedge cpci_clk);
         waited++;
         if (waited > WAIT_LIMIT)
            report_timeout("a receive word");
      end
      // no word beyond the credits granted
      repeat (4) @(negedge cpci_clk);
      check(test_name, granted, rx_log.size());
   end
   while (exp_rx.size() > 0)
      check(test_name, exp_rx.pop_front(), rx_log.pop_front());
endtask

//////////////////////////////////////////////////
// register bus
task automatic reg_access(input logic rd_wr_l, input logic [REG_ADDR_WIDTH-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
   int waited;
   waited = 0;
   @(posedge cpci_clk);
   reg_req     <= 1'b1;
   reg_rd_wr_l <= rd_wr_l;
   reg_addr    <= addr;
   reg_wr_data <= wdata;
   @(posedge cpci_clk);
   reg_req <= 1'b0;
   @(negedge cpci_clk);
   while (!reg_ack) begin
      waited++;
      if (waited > WAIT_LIMIT)
         report_timeout("the register ack");
      @(negedge cpci_clk);
   end
   rdata = reg_rd_data;
endtask

task automatic reg_read(input logic [REG_ADDR_WIDTH-1:0] addr, output logic [31:0] rdata);
   reg_access(1'b1, addr, 32'h0, rdata);
endtask

task automatic reg_write(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] wdata);
   logic [31:0] unused_rdata;
   reg_access(1'b0, addr, wdata, unused_rdata);
endtask

`endif

// ==== tests/tb_cpci_dma.sv ====
// testbench for the dma engine
//   clock, reset and DUT instance
//   core queue models and host credit monitor
//   directed tests for tx, back-pressure, rx credits and registers
`timescale 1ns/1ps
`default_nettype none

module tb_cpci_dma;

   import dma_pkg::*;

   localparam int WORD_BITS  = $bits(dma_word_u);
   localparam int WAIT_LIMIT = 2000;

   logic                      cpci_clk;
   logic                      rst_n;
   logic                      dma_vld_c2n;
   logic                      dma_is_req_c2n;
   dma_word_u                 dma_word_c2n;
   logic                      dma_credit_n2c;
   logic                      dma_vld_n2c;
   dma_word_u                 dma_word_n2c;
   logic                      dma_credit_c2n;
   logic [NUM_CPU_QUEUES-1:0] cpu_q_nearly_full;
   logic [NUM_CPU_QUEUES-1:0] cpu_q_wr;
   dma_word_u                 cpu_q_wr_word [NUM_CPU_QUEUES];
   logic [NUM_CPU_QUEUES-1:0] cpu_q_pkt_avail;
   logic [NUM_CPU_QUEUES-1:0] cpu_q_rd;
   dma_word_u                 cpu_q_rd_word [NUM_CPU_QUEUES];
   logic                      reg_req;
   logic                      reg_rd_wr_l;
   logic [REG_ADDR_WIDTH-1:0] reg_addr;
   logic [REG_DATA_WIDTH-1:0] reg_wr_data;
   logic [REG_DATA_WIDTH-1:0] reg_rd_data;
   logic                      reg_ack;

   // host side bookkeeping
   int        credits_back = 0;
   int        words_sent   = 0;
   int        error_count  = 0;
   logic [31:0] rng_state  = 32'd72;
   // core write log and expected writes, tagged with queue id
   logic [QID_WIDTH+WORD_BITS-1:0] wr_log [$];
   logic [QID_WIDTH+WORD_BITS-1:0] exp_wr [$];
   // scripted rx packet for one core queue, and words seen by the host
   dma_word_u rx_src [$];
   int        rx_src_qid = 0;
   dma_word_u rx_log [$];

   `include "tb_cpci_dma_tasks.svh"

   cpci_dma u_cpci_dma (
      .cpci_clk          (cpci_clk),
      .rst_n             (rst_n),
      .dma_vld_c2n       (dma_vld_c2n),
      .dma_is_req_c2n    (dma_is_req_c2n),
      .dma_word_c2n      (dma_word_c2n),
      .dma_credit_n2c    (dma_credit_n2c),
      .dma_vld_n2c       (dma_vld_n2c),
      .dma_word_n2c      (dma_word_n2c),
      .dma_credit_c2n    (dma_credit_c2n),
      .cpu_q_nearly_full (cpu_q_nearly_full),
      .cpu_q_wr          (cpu_q_wr),
      .cpu_q_wr_word     (cpu_q_wr_word),
      .cpu_q_pkt_avail   (cpu_q_pkt_avail),
      .cpu_q_rd          (cpu_q_rd),
      .cpu_q_rd_word     (cpu_q_rd_word),
      .reg_req           (reg_req),
      .reg_rd_wr_l       (reg_rd_wr_l),
      .reg_addr          (reg_addr),
      .reg_wr_data       (reg_wr_data),
      .reg_rd_data       (reg_rd_data),
      .reg_ack           (reg_ack)
   );

   initial begin
      cpci_clk = 1'b0;
      forever #50 cpci_clk = ~cpci_clk;
   end

   //////////////////////////////////////////////////
   // core queue models and host monitor
   always @(posedge cpci_clk) begin
      if (dma_credit_n2c)
         credits_back <= credits_back + 1;
      if (dma_vld_n2c)
         rx_log.push_back(dma_word_n2c);
      for (int i = 0; i < NUM_CPU_QUEUES; i++) begin
         if (cpu_q_wr[i])
            wr_log.push_back({QID_WIDTH'(i), cpu_q_wr_word[i]});
         // read data follows the read by one cycle
         if (cpu_q_rd[i])
            cpu_q_rd_word[i] <= rx_src.pop_front();
      end
      cpu_q_pkt_avail <= (rx_src.size() != 0) ? (NUM_CPU_QUEUES'(1) << rx_src_qid) : '0;
   end

   //////////////////////////////////////////////////
   // directed tests
   task automatic check_reset_state();
      logic [31:0] rdata;
      @(negedge cpci_clk);
      check("reset_state", 0, dma_vld_n2c);
      check("reset_state", 0, dma_credit_n2c);
      check("reset_state", 0, cpu_q_wr);
      check("reset_state", 0, cpu_q_rd);
      check("reset_state", 0, reg_ack);
      reg_read(REG_TX_PKTS, rdata);
      check("reset_state", 0, rdata);
      reg_read(REG_RX_PKTS, rdata);
      check("reset_state", 0, rdata);
      // disable bit clear means enabled
      reg_read(REG_CTRL, rdata);
      check("reset_state", 0, rdata);
   endtask

   task automatic tx_to_each_queue();
      for (int q = 0; q < NUM_CPU_QUEUES; q++) begin
         tx_packet(q, 1 + int'(next_rand() % 8));
         expect_core_writes("tx_each_queue");
      end
   endtask

   task automatic tx_under_backpressure();
      int q;
      q = int'(next_rand() % NUM_CPU_QUEUES);
      @(posedge cpci_clk);
      cpu_q_nearly_full[q] <= 1'b1;
      tx_request(q);
      // fills the port buffer, then the host fsm input buffer
      tx_data(q, TX_DEPTH + HOST_CREDITS, 1'b0);
      host_idle();
      repeat (20) begin
         @(negedge cpci_clk);
         check("backpressure", 0, cpu_q_wr[q]);
      end
      check("backpressure", 0, HOST_CREDITS + credits_back - words_sent);
      @(posedge cpci_clk);
      cpu_q_nearly_full[q] <= 1'b0;
      tx_data(q, 2, 1'b1);
      host_idle();
      expect_core_writes("backpressure");
      wait_credits_home();
      check("backpressure", HOST_CREDITS, HOST_CREDITS + credits_back - words_sent);
   endtask

   task automatic rx_with_single_credits();
      for (int q = 0; q < NUM_CPU_QUEUES; q++)
         rx_packet("rx_credits", q, 6 + int'(next_rand() % 4));
   endtask

   task automatic counters_and_disable();
      logic [31:0] rdata;
      // any write data clears a counter
      reg_write(REG_TX_PKTS, 32'hffff_ffff);
      reg_write(REG_RX_PKTS, 32'hffff_ffff);
      for (int n = 0; n < 3; n++) begin
         tx_packet(n, 2 + n);
         expect_core_writes("counters");
      end
      for (int n = 0; n < 2; n++)
         rx_packet("counters", n + 1, 3);
      reg_read(REG_TX_PKTS, rdata);
      check("counters", 3, rdata);
      reg_read(REG_RX_PKTS, rdata);
      check("counters", 2, rdata);
      // disabled, host words sit in the input buffer
      reg_write(REG_CTRL, 32'h1);
      tx_packet(3, 3);
      repeat (20) begin
         @(negedge cpci_clk);
         check("disable", 0, cpu_q_wr);
      end
      reg_write(REG_CTRL, 32'h0);
      expect_core_writes("disable");
   endtask

   initial begin
      rst_n             = 1'b0;
      dma_vld_c2n       = 1'b0;
      dma_is_req_c2n    = 1'b0;
      dma_word_c2n      = '0;
      dma_credit_c2n    = 1'b0;
      cpu_q_nearly_full = '0;
      cpu_q_pkt_avail   = '0;
      for (int i = 0; i < NUM_CPU_QUEUES; i++)
         cpu_q_rd_word[i] = '0;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b1;
      reg_addr    = '0;
      reg_wr_data = '0;
      repeat (16) @(posedge cpci_clk);
      rst_n <= 1'b1;
      @(posedge cpci_clk);
      check_reset_state();
      tx_to_each_queue();
      tx_under_backpressure();
      rx_with_single_credits();
      counters_and_disable();
      if (error_count == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         stop_with_failure();
      end
   end

endmodule

`default_nettype wire

// ==== source/cpci_dma.sv ====
// dma engine top level
//   host fsm, one queue port per cpu queue
//   rx mux and register block
`timescale 1ns/1ps
`default_nettype none

module cpci_dma (
   input  wire                                 cpci_clk,
   input  wire                                 rst_n,
   // host to dma
   input  wire                                 dma_vld_c2n,
   input  wire                                 dma_is_req_c2n,
   input  wire dma_pkg::dma_word_u             dma_word_c2n,
   output logic                                dma_credit_n2c,
   // dma to host
   output logic                                dma_vld_n2c,
   output dma_pkg::dma_word_u                  dma_word_n2c,
   input  wire                                 dma_credit_c2n,
   // core queues
   input  wire [dma_pkg::NUM_CPU_QUEUES-1:0]   cpu_q_nearly_full,
   output logic [dma_pkg::NUM_CPU_QUEUES-1:0]  cpu_q_wr,
   output dma_pkg::dma_word_u                  cpu_q_wr_word [dma_pkg::NUM_CPU_QUEUES],
   input  wire [dma_pkg::NUM_CPU_QUEUES-1:0]   cpu_q_pkt_avail,
   output logic [dma_pkg::NUM_CPU_QUEUES-1:0]  cpu_q_rd,
   input  wire dma_pkg::dma_word_u             cpu_q_rd_word [dma_pkg::NUM_CPU_QUEUES],
   // register bus
   input  wire                                 reg_req,
   input  wire                                 reg_rd_wr_l,
   input  wire [dma_pkg::REG_ADDR_WIDTH-1:0]   reg_addr,
   input  wire [dma_pkg::REG_DATA_WIDTH-1:0]   reg_wr_data,
   output logic [dma_pkg::REG_DATA_WIDTH-1:0]  reg_rd_data,
   output logic                                reg_ack
);

   import dma_pkg::*;

   // host fsm to queue ports
   logic [NUM_CPU_QUEUES-1:0] tx_push;
   logic [NUM_CPU_QUEUES-1:0] tx_credit;
   dma_word_u                 tx_word;
   // queue ports to rx mux
   logic [NUM_CPU_QUEUES-1:0] rx_pop;
   logic [NUM_CPU_QUEUES-1:0] rx_head_vld;
   dma_word_u                 rx_head_word [NUM_CPU_QUEUES];
   // fsm, mux and registers
   logic                      rx_start;
   logic [QID_WIDTH-1:0]      rx_qid;
   logic                      rx_done;
   logic                      tx_pkt;
   logic                      rx_pkt;
   logic                      dma_enable;

   dma_host_fsm u_host_fsm (
      .cpci_clk       (cpci_clk),
      .rst_n          (rst_n),
      .dma_vld_c2n    (dma_vld_c2n),
      .dma_is_req_c2n (dma_is_req_c2n),
      .dma_word_c2n   (dma_word_c2n),
      .tx_credit      (tx_credit),
      .rx_done        (rx_done),
      .dma_enable     (dma_enable),
      .dma_credit_n2c (dma_credit_n2c),
      .tx_push        (tx_push),
      .tx_word        (tx_word),
      .rx_start       (rx_start),
      .rx_qid         (rx_qid),
      .tx_pkt         (tx_pkt)
   );

   //////////////////////////////////////////////////
   // one port per cpu queue
   for (genvar i = 0; i < NUM_CPU_QUEUES; i++) begin : g_port
      dma_queue_port u_queue_port (
         .cpci_clk          (cpci_clk),
         .rst_n             (rst_n),
         .tx_push           (tx_push[i]),
         .tx_word           (tx_word),
         .cpu_q_nearly_full (cpu_q_nearly_full[i]),
         .cpu_q_pkt_avail   (cpu_q_pkt_avail[i]),
         .cpu_q_rd_word     (cpu_q_rd_word[i]),
         .rx_pop            (rx_pop[i]),
         .tx_credit         (tx_credit[i]),
         .cpu_q_wr          (cpu_q_wr[i]),
         .cpu_q_wr_word     (cpu_q_wr_word[i]),
         .cpu_q_rd          (cpu_q_rd[i]),
         .rx_head_vld       (rx_head_vld[i]),
         .rx_head_word      (rx_head_word[i])
      );
   end

   dma_rx_mux u_rx_mux (
      .cpci_clk       (cpci_clk),
      .rst_n          (rst_n),
      .rx_start       (rx_start),
      .rx_qid         (rx_qid),
      .rx_head_vld    (rx_head_vld),
      .rx_head_word   (rx_head_word),
      .dma_credit_c2n (dma_credit_c2n),
      .dma_enable     (dma_enable),
      .rx_pop         (rx_pop),
      .dma_vld_n2c    (dma_vld_n2c),
      .dma_word_n2c   (dma_word_n2c),
      .rx_done        (rx_done),
      .rx_pkt         (rx_pkt)
   );

   dma_regs u_regs (
      .cpci_clk    (cpci_clk),
      .rst_n       (rst_n),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .tx_pkt      (tx_pkt),
      .rx_pkt      (rx_pkt),
      .reg_rd_data (reg_rd_data),
      .reg_ack     (reg_ack),
      .dma_enable  (dma_enable)
   );

endmodule

`default_nettype wire

// ==== source/dma_regs.sv ====
// dma register block
//   control register with the disable bit
//   tx and rx packet counters, cleared on write
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
   input  wire                                cpci_clk,
   input  wire                                rst_n,
   input  wire                                reg_req,
   input  wire                                reg_rd_wr_l,
   input  wire [dma_pkg::REG_ADDR_WIDTH-1:0]  reg_addr,
   input  wire [dma_pkg::REG_DATA_WIDTH-1:0]  reg_wr_data,
   input  wire                                tx_pkt,
   input  wire                                rx_pkt,
   output logic [dma_pkg::REG_DATA_WIDTH-1:0] reg_rd_data,
   output logic                               reg_ack,
   output logic                               dma_enable
);

   import dma_pkg::*;

   logic                      dma_disable;
   logic [REG_DATA_WIDTH-1:0] tx_pkts;
   logic [REG_DATA_WIDTH-1:0] rx_pkts;
   logic                      reg_wr;

   assign reg_wr     = reg_req && !reg_rd_wr_l;
   assign dma_enable = !dma_disable;

   //////////////////////////////////////////////////
   // writes and counters
   always_ff @(posedge cpci_clk) begin
      if (!rst_n) begin
         dma_disable <= 1'b0;
         tx_pkts     <= '0;
         rx_pkts     <= '0;
         reg_ack     <= 1'b0;
      end else begin
         reg_ack <= reg_req;
         if (reg_wr && (reg_addr == REG_CTRL))
            dma_disable <= reg_wr_data[0];
         // a write clears, whatever the data
         if (reg_wr && (reg_addr == REG_TX_PKTS))
            tx_pkts <= '0;
         else if (tx_pkt)
            tx_pkts <= tx_pkts + 1'b1;
         if (reg_wr && (reg_addr == REG_RX_PKTS))
            rx_pkts <= '0;
         else if (rx_pkt)
            rx_pkts <= rx_pkts + 1'b1;
      end
   end

   // read data lines up with the ack
   always_ff @(posedge cpci_clk) begin
      if (reg_req && reg_rd_wr_l) begin
         case (reg_addr)
            REG_CTRL:    reg_rd_data <= {{(REG_DATA_WIDTH-1){1'b0}}, dma_disable};
            REG_TX_PKTS: reg_rd_data <= tx_pkts;
            REG_RX_PKTS: reg_rd_data <= rx_pkts;
            default:     reg_rd_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/dma_rx_mux.sv ====
// rx packet mux
//   selects one queue port's prefetch head
//   streams words to the host under host credits up to eop
`timescale 1ns/1ps
`default_nettype none

module dma_rx_mux (
   input  wire                                cpci_clk,
   input  wire                                rst_n,
   input  wire                                rx_start,
   input  wire [dma_pkg::QID_WIDTH-1:0]       rx_qid,
   input  wire [dma_pkg::NUM_CPU_QUEUES-1:0]  rx_head_vld,
   input  wire dma_pkg::dma_word_u            rx_head_word [dma_pkg::NUM_CPU_QUEUES],
   input  wire                                dma_credit_c2n,
   input  wire                                dma_enable,
   output logic [dma_pkg::NUM_CPU_QUEUES-1:0] rx_pop,
   output logic                               dma_vld_n2c,
   output dma_pkg::dma_word_u                 dma_word_n2c,
   output logic                               rx_done,
   output logic                               rx_pkt
);

   import dma_pkg::*;

   logic                       busy;
   logic [QID_WIDTH-1:0]       sel;
   logic [RX_CREDIT_WIDTH-1:0] credit_cnt;
   logic                       send;
   dma_word_u                  sel_word;

   assign sel_word = rx_head_word[sel];

   // one word per host credit
   assign send = busy && dma_enable && rx_head_vld[sel] && (credit_cnt != '0);

   always_comb begin
      rx_pop      = '0;
      rx_pop[sel] = send;
   end

   always_ff @(posedge cpci_clk) begin
      if (!rst_n) begin
         busy        <= 1'b0;
         sel         <= '0;
         credit_cnt  <= '0;
         dma_vld_n2c <= 1'b0;
         rx_done     <= 1'b0;
         rx_pkt      <= 1'b0;
      end else begin
         dma_vld_n2c <= send;
         rx_done     <= 1'b0;
         rx_pkt      <= 1'b0;
         credit_cnt  <= credit_cnt + RX_CREDIT_WIDTH'(dma_credit_c2n)
                        - RX_CREDIT_WIDTH'(send);
         if (rx_start) begin
            busy <= 1'b1;
            sel  <= rx_qid;
         end else if (send && sel_word.data_w.eop) begin
            // packet finished, release the host fsm
            busy    <= 1'b0;
            rx_done <= 1'b1;
            rx_pkt  <= 1'b1;
         end
      end
   end

   always_ff @(posedge cpci_clk) begin
      if (send)
         dma_word_n2c <= sel_word;
   end

endmodule

`default_nettype wire

// ==== source/dma_queue_port.sv ====
// one cpu queue port
//   tx buffer draining to the core queue, credit per drained word
//   rx prefetch buffer filled from the core queue
`timescale 1ns/1ps
`default_nettype none

module dma_queue_port (
   input  wire                      cpci_clk,
   input  wire                      rst_n,
   input  wire                      tx_push,
   input  wire dma_pkg::dma_word_u  tx_word,
   input  wire                      cpu_q_nearly_full,
   input  wire                      cpu_q_pkt_avail,
   input  wire dma_pkg::dma_word_u  cpu_q_rd_word,
   input  wire                      rx_pop,
   output logic                     tx_credit,
   output logic                     cpu_q_wr,
   output dma_pkg::dma_word_u       cpu_q_wr_word,
   output logic                     cpu_q_rd,
   output logic                     rx_head_vld,
   output dma_pkg::dma_word_u       rx_head_word
);

   import dma_pkg::*;

   // tx side
   dma_word_u               tx_mem [TX_DEPTH];
   logic [TX_PTR_WIDTH-1:0] tx_wr_ptr;
   logic [TX_PTR_WIDTH-1:0] tx_rd_ptr;
   logic [TX_CNT_WIDTH-1:0] tx_cnt;
   logic                    tx_drain;

   // rx side
   dma_word_u               rx_mem [RX_DEPTH];
   logic [RX_PTR_WIDTH-1:0] rx_wr_ptr;
   logic [RX_PTR_WIDTH-1:0] rx_rd_ptr;
   logic [RX_CNT_WIDTH-1:0] rx_cnt;
   // read issued last cycle, its word is on cpu_q_rd_word now
   logic                    rd_in_flight;

   // drain whenever the core queue has room
   assign tx_drain = (tx_cnt != '0) && !cpu_q_nearly_full;

   // room must cover stored words plus the one in flight
   assign cpu_q_rd = cpu_q_pkt_avail && ((rx_cnt + rd_in_flight) < RX_DEPTH);

   assign rx_head_vld  = (rx_cnt != '0);
   assign rx_head_word = rx_mem[rx_rd_ptr];

   //////////////////////////////////////////////////
   // buffer storage and core write data
   always_ff @(posedge cpci_clk) begin
      if (tx_push)
         tx_mem[tx_wr_ptr] <= tx_word;
      if (tx_drain)
         cpu_q_wr_word <= tx_mem[tx_rd_ptr];
      if (rd_in_flight)
         rx_mem[rx_wr_ptr] <= cpu_q_rd_word;
   end

   //////////////////////////////////////////////////
   // pointers and counts
   always_ff @(posedge cpci_clk) begin
      if (!rst_n) begin
         tx_wr_ptr    <= '0;
         tx_rd_ptr    <= '0;
         tx_cnt       <= '0;
         cpu_q_wr     <= 1'b0;
         tx_credit    <= 1'b0;
         rx_wr_ptr    <= '0;
         rx_rd_ptr    <= '0;
         rx_cnt       <= '0;
         rd_in_flight <= 1'b0;
      end else begin
         // tx
         if (tx_push)
            tx_wr_ptr <= tx_wr_ptr + 1'b1;
         if (tx_drain)
            tx_rd_ptr <= tx_rd_ptr + 1'b1;
         tx_cnt    <= tx_cnt + TX_CNT_WIDTH'(tx_push) - TX_CNT_WIDTH'(tx_drain);
         cpu_q_wr  <= tx_drain;
         tx_credit <= tx_drain;
         // rx
         rd_in_flight <= cpu_q_rd;
         if (rd_in_flight)
            rx_wr_ptr <= rx_wr_ptr + 1'b1;
         if (rx_pop)
            rx_rd_ptr <= rx_rd_ptr + 1'b1;
         rx_cnt <= rx_cnt + RX_CNT_WIDTH'(rd_in_flight) - RX_CNT_WIDTH'(rx_pop);
      end
   end

endmodule

`default_nettype wire

// ==== source/dma_host_fsm.sv ====
// host side of the dma engine
//   host word input buffer with credit return
//   request / data decode of the head word
//   dispatch to queue ports under per-port credits
`timescale 1ns/1ps
`default_nettype none

module dma_host_fsm (
   input  wire                               cpci_clk,
   input  wire                               rst_n,
   input  wire                               dma_vld_c2n,
   input  wire                               dma_is_req_c2n,
   input  wire dma_pkg::dma_word_u           dma_word_c2n,
   input  wire [dma_pkg::NUM_CPU_QUEUES-1:0] tx_credit,
   input  wire                               rx_done,
   input  wire                               dma_enable,
   output logic                              dma_credit_n2c,
   output logic [dma_pkg::NUM_CPU_QUEUES-1:0] tx_push,
   output dma_pkg::dma_word_u                tx_word,
   output logic                              rx_start,
   output logic [dma_pkg::QID_WIDTH-1:0]     rx_qid,
   output logic                              tx_pkt
);

   import dma_pkg::*;

   // input buffer, one entry per host credit
   logic                      buf_is_req [HOST_CREDITS];
   dma_word_u                 buf_word [HOST_CREDITS];
   logic [HOST_PTR_WIDTH-1:0] wr_ptr;
   logic [HOST_PTR_WIDTH-1:0] rd_ptr;
   logic [HOST_CNT_WIDTH-1:0] buf_cnt;

   // head word decode
   logic                      head_vld;
   logic                      head_is_req;
   dma_word_u                 head_word;
   logic [QID_WIDTH-1:0]      head_qid;
   logic                      pop;
   logic                      pop_data;

   // dispatch state
   logic [QID_WIDTH-1:0]      tx_port;
   logic                      rx_busy;
   logic [TX_CNT_WIDTH-1:0]   tx_cnt [NUM_CPU_QUEUES];

   assign head_vld    = (buf_cnt != '0);
   assign head_is_req = buf_is_req[rd_ptr];
   assign head_word   = buf_word[rd_ptr];
   assign head_qid    = head_word.req_w.arg[QID_WIDTH-1:0];

   // pop only when the head word can move on
   always_comb begin
      pop = 1'b0;
      if (head_vld && dma_enable) begin
         if (head_is_req)
            // requests wait for the running rx packet
            pop = !rx_busy;
         else
            pop = (tx_cnt[tx_port] != '0);
      end
   end

   assign pop_data = pop && !head_is_req;

   //////////////////////////////////////////////////
   // input buffer
   always_ff @(posedge cpci_clk) begin
      if (dma_vld_c2n) begin
         buf_is_req[wr_ptr] <= dma_is_req_c2n;
         buf_word[wr_ptr]   <= dma_word_c2n;
      end
   end

   always_ff @(posedge cpci_clk) begin
      if (!rst_n) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         buf_cnt        <= '0;
         dma_credit_n2c <= 1'b0;
      end else begin
         if (dma_vld_c2n)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         buf_cnt <= buf_cnt + HOST_CNT_WIDTH'(dma_vld_c2n) - HOST_CNT_WIDTH'(pop);
         // freed entry goes back to the host next cycle
         dma_credit_n2c <= pop;
      end
   end

   //////////////////////////////////////////////////
   // decode and dispatch
   always_ff @(posedge cpci_clk) begin
      if (!rst_n) begin
         tx_port  <= '0;
         rx_busy  <= 1'b0;
         rx_start <= 1'b0;
         rx_qid   <= '0;
         tx_push  <= '0;
         tx_pkt   <= 1'b0;
         for (int i = 0; i < NUM_CPU_QUEUES; i++)
            tx_cnt[i] <= TX_CNT_WIDTH'(TX_DEPTH);
      end else begin
         rx_start <= 1'b0;
         tx_push  <= '0;
         tx_pkt   <= 1'b0;
         if (rx_done)
            rx_busy <= 1'b0;
         if (pop && head_is_req) begin
            if (head_word.req_w.dir_rx) begin
               rx_start <= 1'b1;
               rx_qid   <= head_qid;
               rx_busy  <= 1'b1;
            end else begin
               // later data words go to this port
               tx_port <= head_qid;
            end
         end
         if (pop_data) begin
            tx_push[tx_port] <= 1'b1;
            tx_pkt           <= head_word.data_w.eop;
         end
         // one credit spent per push, one back per drained word
         for (int i = 0; i < NUM_CPU_QUEUES; i++)
            tx_cnt[i] <= tx_cnt[i] + TX_CNT_WIDTH'(tx_credit[i])
                         - TX_CNT_WIDTH'(pop_data && (tx_port == i));
      end
   end

   // shared tx data bus to all ports
   always_ff @(posedge cpci_clk) begin
      if (pop_data)
         tx_word <= head_word;
   end

endmodule

`default_nettype wire

// ==== source/dma_pkg.sv ====
// dma engine shared definitions
//   queue, buffer and register sizes
//   derived pointer and counter widths
//   host word union with data and request views
`default_nettype none

package dma_pkg;

   //////////////////////////////////////////////////
   // sizes
   localparam int NUM_CPU_QUEUES  = 4;
   localparam int DMA_DATA_WIDTH  = 32;
   localparam int QID_WIDTH       = 2;
   // tx buffer depth, also the initial credit count per port
   localparam int TX_DEPTH        = 4;
   localparam int RX_DEPTH        = 4;
   // host input buffer entries = host credits after reset
   localparam int HOST_CREDITS    = 4;
   localparam int RX_CREDIT_WIDTH = 8;

   // derived widths
   localparam int HOST_PTR_WIDTH  = $clog2(HOST_CREDITS);
   localparam int HOST_CNT_WIDTH  = $clog2(HOST_CREDITS + 1);
   localparam int TX_PTR_WIDTH    = $clog2(TX_DEPTH);
   localparam int TX_CNT_WIDTH    = $clog2(TX_DEPTH + 1);
   localparam int RX_PTR_WIDTH    = $clog2(RX_DEPTH);
   localparam int RX_CNT_WIDTH    = $clog2(RX_DEPTH + 1);

   //////////////////////////////////////////////////
   // register map
   localparam int REG_ADDR_WIDTH  = 2;
   localparam int REG_DATA_WIDTH  = 32;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL    = 2'd0;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_TX_PKTS = 2'd1;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_RX_PKTS = 2'd2;

   //////////////////////////////////////////////////
   // host word, view chosen by dma_is_req_c2n
   // byte_cnt 00 = four bytes, 01 = one, 10 = two, 11 = three
   typedef union packed {
      struct packed {
         logic                      eop;
         logic [1:0]                byte_cnt;
         logic [DMA_DATA_WIDTH-1:0] data;
      } data_w;
      // request view, queue id in the low bits of arg
      struct packed {
         logic                      dir_rx;
         logic [1:0]                rsvd;
         logic [DMA_DATA_WIDTH-1:0] arg;
      } req_w;
   } dma_word_u;

endpackage

`default_nettype wire
